//--- Makefile
.PHONY: all run clean

all: run

obj_dir/Vtb_user_io: src.f $(shell cat src.f)
	verilator --binary --timing -Wno-fatal --top-module tb_user_io -f src.f

run: obj_dir/Vtb_user_io
	@out="$$(./obj_dir/Vtb_user_io)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir

//--- cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder #(
    parameter int NUM_JOY = 4
) (
    input  logic                   clk_sys,
    input  user_io_pkg::spi_byte_t rx_byte,
    input  logic                   rx_toggle,
    input  logic                   xfer_idle,
    output logic [1:0]             byte_sel,
    output user_io_pkg::spi_byte_t wr_byte,
    output logic [NUM_JOY-1:0]     joy_load,
    output logic                   size_load,
    output logic                   but_load,
    output logic                   kbd_ack,
    output logic                   kbd_wr,
    output logic [1:0]             img_mounted
);

    logic                   toggle_meta;
    logic                   toggle_sync;
    logic                   toggle_seen;
    logic                   idle_meta;
    logic                   idle_sync;

    logic                   byte_event;
    logic                   payload;
    logic                   in_word;

    user_io_pkg::spi_byte_t cmd;
    user_io_pkg::byte_idx_t byte_cnt;

    logic [NUM_JOY-1:0]     joy_load_d;
    logic [1:0]             byte_sel_d;

    // two-flop synchronizers from the SPI_CLK domain
    always_ff @(posedge clk_sys) begin
        toggle_meta <= rx_toggle;
        toggle_sync <= toggle_meta;
        toggle_seen <= toggle_sync;
        idle_meta   <= xfer_idle;
        idle_sync   <= idle_meta;
    end

    // rx_byte has been stable for at least two clk_sys periods here
    assign byte_event = (toggle_sync != toggle_seen) && !idle_sync;
    assign payload    = byte_event && (byte_cnt != '0);
    assign in_word    = (byte_cnt >= 8'd1) && (byte_cnt <= 8'd4);

    always_comb begin
        for (int j = 0; j < NUM_JOY; j++) begin
            joy_load_d[j] = payload && in_word &&
                (cmd == user_io_pkg::spi_byte_t'(user_io_pkg::CMD_JOY_BASE + j));
        end
    end

    // payload bytes 1..4 land in lanes 0..3
    assign byte_sel_d = (cmd == user_io_pkg::CMD_BUTTONS) ? 2'd0 : byte_cnt[1:0] - 2'd1;

    always_ff @(posedge clk_sys) begin
        if (idle_sync) begin
            byte_cnt    <= '0;
            joy_load    <= '0;
            size_load   <= 1'b0;
            but_load    <= 1'b0;
            kbd_ack     <= 1'b0;
            kbd_wr      <= 1'b0;
            img_mounted <= 2'b00;
        end else begin
            if (byte_event && byte_cnt != '1) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            joy_load  <= joy_load_d;
            size_load <= payload && in_word && (cmd == user_io_pkg::CMD_IMG_SIZE);
            but_load  <= payload && (cmd == user_io_pkg::CMD_BUTTONS);
            kbd_ack   <= payload && (byte_cnt == 8'd1) && (cmd == user_io_pkg::CMD_KBD_OUT);
            kbd_wr    <= payload && (byte_cnt == 8'd1) && (cmd == user_io_pkg::CMD_KBD_IN);
            img_mounted <= 2'b00;
            if (payload && (byte_cnt == 8'd1) && (cmd == user_io_pkg::CMD_MOUNT)) begin
                img_mounted[rx_byte[0]] <= 1'b1;
            end
        end
    end

    // command and write data follow each accepted byte
    always_ff @(posedge clk_sys) begin
        if (byte_event) begin
            if (byte_cnt == '0) begin
                cmd <= rx_byte;
            end
            wr_byte  <= rx_byte;
            byte_sel <= byte_sel_d;
        end
    end

    a_single_load: assert property (
        @(posedge clk_sys) disable iff (idle_sync)
        $onehot0({joy_load, size_load, but_load, kbd_ack, kbd_wr})
    );

    // mount notification is a single-cycle pulse on one drive
    a_mount_pulse: assert property (
        @(posedge clk_sys)
        (img_mounted != 2'b00) |-> $onehot(img_mounted) ##1 (img_mounted == 2'b00)
    );

endmodule

//--- field_reg.sv
`timescale 1ns/1ps

module field_reg #(
    parameter type T = user_io_pkg::joy_state_t
) (
    input  logic                   clk_sys,
    input  logic                   load,
    input  logic [1:0]             byte_sel,
    input  user_io_pkg::spi_byte_t wr_byte,
    output T                       value
);

    // number of byte lanes in the payload
    localparam int LANES = $bits(T) / 8;

    // each lane keeps its contents until the host rewrites it
    always_ff @(posedge clk_sys) begin
        for (int i = 0; i < LANES; i++) begin
            if (load && (byte_sel == i)) begin
                value[i*8 +: 8] <= wr_byte;
            end
        end
    end

    // the decoder must not address a lane this payload lacks
    a_lane_in_range: assert property (
        @(posedge clk_sys) load |-> (int'(byte_sel) < LANES)
    );

endmodule

//--- kbd_port.sv
`timescale 1ns/1ps

module kbd_port (
    input  logic                   clk_sys,
    input  logic                   kbd_out_strobe,
    input  logic                   kbd_ack,
    input  logic                   kbd_wr,
    input  user_io_pkg::spi_byte_t wr_byte,
    output logic                   kbd_avail,
    output user_io_pkg::spi_byte_t kbd_in_data,
    output logic                   kbd_in_strobe
);

    // nothing pending after configuration
    logic avail_q = 1'b0;

    // a new byte from the core wins over a host acknowledge
    always_ff @(posedge clk_sys) begin
        if (kbd_out_strobe) begin
            avail_q <= 1'b1;
        end else if (kbd_ack) begin
            avail_q <= 1'b0;
        end
    end

    assign kbd_avail = avail_q;

    always_ff @(posedge clk_sys) begin
        kbd_in_strobe <= kbd_wr;
    end

    // data is valid together with the strobe
    always_ff @(posedge clk_sys) begin
        if (kbd_wr) begin
            kbd_in_data <= wr_byte;
        end
    end

endmodule

//--- spi_frontend.sv
`timescale 1ns/1ps

module spi_frontend (
    input  logic                  SPI_CLK,
    input  logic                  SPI_SS_IO,
    input  logic                  spi_mosi,
    output logic                  spi_miso,
    input  logic                  kbd_avail,
    input  user_io_pkg::spi_byte_t kbd_out_data,
    output user_io_pkg::spi_byte_t rx_byte,
    output logic                  rx_toggle,
    output logic                  xfer_idle
);

    logic [2:0]              bit_cnt;
    user_io_pkg::byte_idx_t  byte_cnt;
    user_io_pkg::spi_byte_t  cmd;
    logic [6:0]              sbuf;

    // starts at a known level so the clk_sys side has a clean reference
    logic                    toggle_q = 1'b0;

    logic                    miso_q;
    logic                    avail_q;
    user_io_pkg::spi_byte_t  kbd_data_q;
    user_io_pkg::spi_byte_t  reply;

    // bit and byte position, command capture
    always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
        if (SPI_SS_IO) begin
            bit_cnt   <= 3'd0;
            byte_cnt  <= '0;
            cmd       <= '0;
            xfer_idle <= 1'b1;
        end else begin
            xfer_idle <= 1'b0;
            bit_cnt   <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
                if (byte_cnt != '1) begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
                if (byte_cnt == '0) begin
                    cmd <= {sbuf, spi_mosi};
                end
            end
        end
    end

    // receive shifter, msb first
    always_ff @(posedge SPI_CLK) begin
        sbuf <= {sbuf[5:0], spi_mosi};
        if (bit_cnt == 3'd7) begin
            rx_byte  <= {sbuf, spi_mosi};
            toggle_q <= ~toggle_q;
        end
    end

    assign rx_toggle = toggle_q;

    // keyboard state sampled from the clk_sys side
    always_ff @(negedge SPI_CLK) begin
        avail_q    <= kbd_avail;
        kbd_data_q <= kbd_out_data;
    end

    always_comb begin
        if (byte_cnt == '0) begin
            reply = user_io_pkg::CORE_TYPE;
        end else if (cmd == user_io_pkg::CMD_KBD_OUT) begin
            if (byte_cnt == 8'd1) begin
                reply = {user_io_pkg::KBD_STATUS_TAG, 3'b000, avail_q};
            end else begin
                reply = kbd_data_q;
            end
        end else begin
            reply = '0;
        end
    end

    // msb of the core type is already waiting when SS drops
    always_ff @(negedge SPI_CLK or posedge SPI_SS_IO) begin
        if (SPI_SS_IO) begin
            miso_q <= user_io_pkg::CORE_TYPE[7];
        end else begin
            miso_q <= reply[~bit_cnt];
        end
    end

    assign spi_miso = SPI_SS_IO ? 1'bz : miso_q;

    // one toggle per completed byte, never mid-byte
    a_toggle_on_byte_end: assert property (
        @(posedge SPI_CLK) disable iff (SPI_SS_IO)
        $changed(rx_toggle) |-> ($past(bit_cnt) == 3'd7)
    );

endmodule

//--- src.f
user_io_pkg.sv
spi_frontend.sv
cmd_decoder.sv
field_reg.sv
kbd_port.sv
user_io.sv
tb_user_io.sv

//--- tb_user_io.sv
`timescale 1ns/1ps

module tb_user_io;

    localparam int NUM_JOY       = 4;
    localparam int MAX_BYTES     = 8;
    localparam int PULSE_TIMEOUT = 64;

    logic                                  clk_sys;
    logic                                  SPI_CLK;
    logic                                  SPI_SS_IO;
    logic                                  spi_mosi;
    wire                                   spi_miso;
    user_io_pkg::spi_byte_t                kbd_out_data;
    logic                                  kbd_out_strobe;
    user_io_pkg::spi_byte_t                kbd_in_data;
    logic                                  kbd_in_strobe;
    user_io_pkg::joy_state_t [NUM_JOY-1:0] joystick;
    user_io_pkg::img_size_t                img_size;
    logic [1:0]                            img_mounted;
    logic [1:0]                            buttons;
    logic [1:0]                            switches;
    logic                                  scandoubler_disable;
    logic                                  ypbpr;

    integer seed = 32'hdc48_1337;

    // bytes sent and captured by the SPI master
    user_io_pkg::spi_byte_t tx_buf [MAX_BYTES];
    user_io_pkg::spi_byte_t rx_buf [MAX_BYTES];

    // expected register state
    user_io_pkg::joy_state_t exp_joy [NUM_JOY];
    logic [NUM_JOY-1:0]      joy_known;
    user_io_pkg::img_size_t  exp_size;
    logic                    size_known;
    user_io_pkg::but_sw_t    exp_but;
    logic                    but_known;
    logic                    exp_avail;
    user_io_pkg::spi_byte_t  exp_kbd_data;

    // 0 keyboard-in strobe, 1 mount drive 0, 2 mount drive 1
    int                      pulse_count [3] = '{0, 0, 0};
    user_io_pkg::spi_byte_t  kbd_in_seen;

    user_io #(
        .NUM_JOY (NUM_JOY)
    ) i_user_io (
        .clk_sys             (clk_sys),
        .SPI_CLK             (SPI_CLK),
        .SPI_SS_IO           (SPI_SS_IO),
        .spi_mosi            (spi_mosi),
        .spi_miso            (spi_miso),
        .kbd_out_data        (kbd_out_data),
        .kbd_out_strobe      (kbd_out_strobe),
        .kbd_in_data         (kbd_in_data),
        .kbd_in_strobe       (kbd_in_strobe),
        .joystick            (joystick),
        .img_size            (img_size),
        .img_mounted         (img_mounted),
        .buttons             (buttons),
        .switches            (switches),
        .scandoubler_disable (scandoubler_disable),
        .ypbpr               (ypbpr)
    );

    // offset keeps clk_sys edges clear of SPI_CLK edges
    initial begin
        clk_sys = 1'b0;
        #3;
        forever #10 clk_sys = ~clk_sys;
    end

    initial begin
        SPI_CLK = 1'b1;
        forever #50 SPI_CLK = ~SPI_CLK;
    end

    // count single-cycle pulses from the DUT
    always @(negedge clk_sys) begin
        if (kbd_in_strobe === 1'b1) begin
            pulse_count[0] = pulse_count[0] + 1;
            kbd_in_seen = kbd_in_data;
        end
        if (img_mounted[0] === 1'b1) begin
            pulse_count[1] = pulse_count[1] + 1;
        end
        if (img_mounted[1] === 1'b1) begin
            pulse_count[2] = pulse_count[2] + 1;
        end
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_byte(input string name, input user_io_pkg::spi_byte_t exp,
                              input user_io_pkg::spi_byte_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_joy(input string name, input user_io_pkg::joy_state_t exp,
                             input user_io_pkg::joy_state_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_size(input string name, input user_io_pkg::img_size_t exp,
                              input user_io_pkg::img_size_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_but_sw(input string name, input user_io_pkg::but_sw_t exp,
                                input user_io_pkg::but_sw_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // reply byte idx for a transfer that starts with cmd
    function automatic user_io_pkg::spi_byte_t expected_reply(
        input user_io_pkg::spi_byte_t cmd, input int idx,
        input logic avail, input user_io_pkg::spi_byte_t kdata);
        if (idx == 0) begin
            return 8'ha6;
        end
        if (cmd != 8'h04) begin
            return 8'h00;
        end
        if (idx == 1) begin
            return {4'ha, 3'b000, avail};
        end
        return kdata;
    endfunction

    // payload bytes 1..4 fill lanes 0..3, or every byte rewrites lane 0
    function automatic logic [31:0] ref_load(input logic [31:0] old, input int len,
                                             input bit one_lane);
        logic [31:0] val;
        val = old;
        for (int i = 1; i < len; i++) begin
            if (one_lane) begin
                val[7:0] = tx_buf[i];
            end else if (i <= 4) begin
                val[(i-1)*8 +: 8] = tx_buf[i];
            end
        end
        return val;
    endfunction

    task automatic spi_xfer(input int len);
        for (int b = 0; b < len; b++) begin
            for (int i = 7; i >= 0; i--) begin
                @(negedge SPI_CLK);
                SPI_SS_IO <= 1'b0;
                spi_mosi  <= tx_buf[b][i];
                @(posedge SPI_CLK);
                rx_buf[b][i] = spi_miso;
            end
        end
        @(negedge SPI_CLK);
        SPI_SS_IO <= 1'b1;
        spi_mosi  <= 1'b0;
        // decoder output settles a few clk_sys cycles after the end
        repeat (8) @(negedge clk_sys);
    endtask

    task automatic check_state(input string name);
        for (int k = 0; k < NUM_JOY; k++) begin
            if (joy_known[k]) begin
                check_joy($sformatf("%s joystick %0d", name, k), exp_joy[k], joystick[k]);
            end
        end
        if (size_known) begin
            check_size({name, " img_size"}, exp_size, img_size);
        end
        if (but_known) begin
            check_but_sw({name, " buttons"}, exp_but & 8'h3f,
                         {2'b00, ypbpr, scandoubler_disable, switches, buttons});
        end
    endtask

    task automatic run_xfer(input string name, input int len);
        user_io_pkg::spi_byte_t cmd;
        logic                   avail;
        user_io_pkg::spi_byte_t kdata;
        logic [31:0]            word;
        int                     ch;
        cmd   = tx_buf[0];
        avail = exp_avail;
        kdata = exp_kbd_data;
        ch    = int'(cmd) - 'h60;
        spi_xfer(len);
        for (int i = 0; i < len; i++) begin
            check_byte($sformatf("%s reply %0d", name, i),
                       expected_reply(cmd, i, avail, kdata), rx_buf[i]);
        end
        if (ch >= 0 && ch < NUM_JOY) begin
            exp_joy[ch]   = ref_load(exp_joy[ch], len, 1'b0);
            joy_known[ch] = 1'b1;
        end
        if (cmd == 8'h1d) begin
            exp_size   = ref_load(exp_size, len, 1'b0);
            size_known = 1'b1;
        end
        if (cmd == 8'h01 && len > 1) begin
            word      = ref_load({24'h0, exp_but}, len, 1'b1);
            exp_but   = word[7:0];
            but_known = 1'b1;
        end
        // reading the status byte acknowledges it
        if (cmd == 8'h04 && len > 1) begin
            exp_avail = 1'b0;
        end
        check_state(name);
    endtask

    task automatic expect_pulses(input string name, input int which, input int target);
        int waited;
        waited = 0;
        while (pulse_count[which] < target && waited < PULSE_TIMEOUT) begin
            @(posedge clk_sys);
            waited++;
        end
        if (pulse_count[which] < target) begin
            $display("timed out waiting for %s", name);
            abort_run();
        end else begin
            repeat (8) @(posedge clk_sys);
            check_count(name, target, pulse_count[which]);
        end
    endtask

    initial begin
        int base_kbd;
        int base_m0;
        int base_m1;
        SPI_SS_IO      = 1'b1;
        spi_mosi       = 1'b0;
        kbd_out_data   = 8'h00;
        kbd_out_strobe = 1'b0;
        joy_known      = '0;
        size_known     = 1'b0;
        but_known      = 1'b0;
        exp_avail      = 1'b0;
        exp_kbd_data   = 8'h00;
        repeat (3) @(negedge SPI_CLK);

        // buttons, switches and video flags, last payload byte wins
        tx_buf[0] = 8'h01;
        tx_buf[1] = 8'h2d;
        run_xfer("buttons", 2);
        tx_buf[1] = 8'($random(seed));
        tx_buf[2] = 8'($random(seed));
        run_xfer("buttons repeated", 3);

        // second pass checks each load against known neighbours
        for (int r = 0; r < 2; r++) begin
            for (int j = 0; j < NUM_JOY; j++) begin
                tx_buf[0] = 8'(8'h60 + j);
                for (int i = 1; i < 7; i++) begin
                    tx_buf[i] = 8'($random(seed));
                end
                run_xfer($sformatf("joystick cmd %0d", j), 7);
            end
        end

        // keyboard byte offered by the core
        exp_kbd_data = 8'($random(seed));
        @(negedge clk_sys);
        kbd_out_data   <= exp_kbd_data;
        kbd_out_strobe <= 1'b1;
        @(negedge clk_sys);
        kbd_out_strobe <= 1'b0;
        exp_avail = 1'b1;
        tx_buf[0] = 8'h04;
        tx_buf[1] = 8'h00;
        tx_buf[2] = 8'h00;
        run_xfer("kbd read", 3);
        run_xfer("kbd read again", 3);

        // keyboard byte from the host
        base_kbd  = pulse_count[0];
        tx_buf[0] = 8'h05;
        tx_buf[1] = 8'($random(seed));
        run_xfer("kbd write", 2);
        expect_pulses("kbd write strobes", 0, base_kbd + 1);
        check_byte("kbd write data", tx_buf[1], kbd_in_seen);

        tx_buf[0] = 8'h1d;
        for (int i = 1; i < 5; i++) begin
            tx_buf[i] = 8'($random(seed));
        end
        run_xfer("image size", 5);

        base_m0   = pulse_count[1];
        base_m1   = pulse_count[2];
        tx_buf[0] = 8'h1c;
        tx_buf[1] = 8'h01;
        run_xfer("mount", 2);
        expect_pulses("mount drive 1 pulses", 2, base_m1 + 1);
        check_count("mount drive 0 pulses", base_m0, pulse_count[1]);

        $display("TEST OK");
        $finish;
    end

endmodule

//--- user_io.sv
`timescale 1ns/1ps

module user_io #(
    parameter int NUM_JOY = 4
) (
    input  logic                                 clk_sys,
    input  logic                                 SPI_CLK,
    input  logic                                 SPI_SS_IO,
    input  logic                                 spi_mosi,
    output logic                                 spi_miso,
    input  user_io_pkg::spi_byte_t               kbd_out_data,
    input  logic                                 kbd_out_strobe,
    output user_io_pkg::spi_byte_t               kbd_in_data,
    output logic                                 kbd_in_strobe,
    output user_io_pkg::joy_state_t [NUM_JOY-1:0] joystick,
    output user_io_pkg::img_size_t               img_size,
    output logic [1:0]                           img_mounted,
    output logic [1:0]                           buttons,
    output logic [1:0]                           switches,
    output logic                                 scandoubler_disable,
    output logic                                 ypbpr
);

    user_io_pkg::spi_byte_t rx_byte;
    logic                   rx_toggle;
    logic                   xfer_idle;
    logic                   kbd_avail;

    logic [1:0]             byte_sel;
    user_io_pkg::spi_byte_t wr_byte;
    logic [NUM_JOY-1:0]     joy_load;
    logic                   size_load;
    logic                   but_load;
    logic                   kbd_ack;
    logic                   kbd_wr;
    user_io_pkg::but_sw_t   but_sw;

    spi_frontend u_frontend (
        .SPI_CLK      (SPI_CLK),
        .SPI_SS_IO    (SPI_SS_IO),
        .spi_mosi     (spi_mosi),
        .spi_miso     (spi_miso),
        .kbd_avail    (kbd_avail),
        .kbd_out_data (kbd_out_data),
        .rx_byte      (rx_byte),
        .rx_toggle    (rx_toggle),
        .xfer_idle    (xfer_idle)
    );

    cmd_decoder #(
        .NUM_JOY (NUM_JOY)
    ) u_decoder (
        .clk_sys     (clk_sys),
        .rx_byte     (rx_byte),
        .rx_toggle   (rx_toggle),
        .xfer_idle   (xfer_idle),
        .byte_sel    (byte_sel),
        .wr_byte     (wr_byte),
        .joy_load    (joy_load),
        .size_load   (size_load),
        .but_load    (but_load),
        .kbd_ack     (kbd_ack),
        .kbd_wr      (kbd_wr),
        .img_mounted (img_mounted)
    );

    kbd_port u_kbd (
        .clk_sys        (clk_sys),
        .kbd_out_strobe (kbd_out_strobe),
        .kbd_ack        (kbd_ack),
        .kbd_wr         (kbd_wr),
        .wr_byte        (wr_byte),
        .kbd_avail      (kbd_avail),
        .kbd_in_data    (kbd_in_data),
        .kbd_in_strobe  (kbd_in_strobe)
    );

    // one joystick word per channel, packed side by side
    for (genvar j = 0; j < NUM_JOY; j++) begin : g_joy
        field_reg #(
            .T (user_io_pkg::joy_state_t)
        ) u_joy (
            .clk_sys  (clk_sys),
            .load     (joy_load[j]),
            .byte_sel (byte_sel),
            .wr_byte  (wr_byte),
            .value    (joystick[j])
        );
    end

    field_reg #(
        .T (user_io_pkg::img_size_t)
    ) u_img_size (
        .clk_sys  (clk_sys),
        .load     (size_load),
        .byte_sel (byte_sel),
        .wr_byte  (wr_byte),
        .value    (img_size)
    );

    field_reg #(
        .T (user_io_pkg::but_sw_t)
    ) u_but_sw (
        .clk_sys  (clk_sys),
        .load     (but_load),
        .byte_sel (byte_sel),
        .wr_byte  (wr_byte),
        .value    (but_sw)
    );

    assign buttons  = but_sw[user_io_pkg::BUT_SW_BUTTONS_LSB +: 2];
    assign switches = but_sw[user_io_pkg::BUT_SW_SWITCHES_LSB +: 2];
    assign scandoubler_disable = but_sw[user_io_pkg::BUT_SW_SCANDBL_BIT];
    assign ypbpr    = but_sw[user_io_pkg::BUT_SW_YPBPR_BIT];

endmodule

//--- user_io_pkg.sv
package user_io_pkg;

    // one byte as it travels over SPI
    typedef logic [7:0] spi_byte_t;

    // byte position within a transfer, saturates at 255
    typedef logic [7:0] byte_idx_t;

    // joystick word, loaded least significant byte first
    typedef logic [31:0] joy_state_t;

    // mounted image size in bytes, least significant byte first
    typedef logic [31:0] img_size_t;

    // buttons, switches and video mode flags
    typedef logic [7:0] but_sw_t;

    // command codes sent by the host as byte 0
    localparam spi_byte_t CMD_BUTTONS  = 8'h01;
    localparam spi_byte_t CMD_KBD_OUT  = 8'h04;
    localparam spi_byte_t CMD_KBD_IN   = 8'h05;
    localparam spi_byte_t CMD_MOUNT    = 8'h1c;
    localparam spi_byte_t CMD_IMG_SIZE = 8'h1d;

    // first of the joystick commands, one code per channel
    localparam spi_byte_t CMD_JOY_BASE = 8'h60;

    // identification byte returned while byte 0 shifts in
    localparam spi_byte_t CORE_TYPE = 8'ha6;

    // upper nibble of the keyboard status reply
    localparam logic [3:0] KBD_STATUS_TAG = 4'ha;

    // field positions inside but_sw_t
    localparam int BUT_SW_BUTTONS_LSB  = 0;
    localparam int BUT_SW_SWITCHES_LSB = 2;
    localparam int BUT_SW_SCANDBL_BIT  = 4;
    localparam int BUT_SW_YPBPR_BIT    = 5;

endpackage
